//--- core_iaddr_trans.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_xlat_cfg.svh"

module core_iaddr_trans
  import csr_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n_i,
  input  wire logic        valid_i,
  input  wire logic [31:0] vaddr_i,
  input  wire logic        stall_i,
  input  wire logic        flush_i,
  input  wire csr_word_t   crmd_i,
  input  wire csr_word_t   dmw0_i,
  input  wire csr_word_t   dmw1_i,
  output logic             valid_o,
  output logic [31:0]      vaddr_o,
  output logic [31:0]      paddr_o,
  output logic             uncached_o,
  output fetch_excp_e      excp_o
);

  logic        da_mode;
  logic        plv0;
  logic        plv3;
  logic        dmw0_hit;
  logic        dmw1_hit;
  mat_t        sel_mat;
  logic [2:0]  sel_pseg;
  logic [31:0] paddr_d;
  fetch_excp_e excp_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // window match
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign da_mode = crmd_i[`CRMD_DA];
  assign plv0    = crmd_i[`CRMD_PLV] == 2'd0;
  assign plv3    = crmd_i[`CRMD_PLV] == 2'd3;

  assign dmw0_hit = ((dmw0_i[`DMW_PLV0] && plv0) || (dmw0_i[`DMW_PLV3] && plv3))
                    && dmw0_i[`DMW_VSEG] == vaddr_i[31:29];
  assign dmw1_hit = ((dmw1_i[`DMW_PLV0] && plv0) || (dmw1_i[`DMW_PLV3] && plv3))
                    && dmw1_i[`DMW_VSEG] == vaddr_i[31:29];

  // dmw0 has priority when both windows hit
  always_comb begin
    if (da_mode) begin
      sel_mat  = crmd_i[`CRMD_DATF];
      sel_pseg = vaddr_i[31:29];
    end else if (dmw0_hit) begin
      sel_mat  = dmw0_i[`DMW_MAT];
      sel_pseg = dmw0_i[`DMW_PSEG];
    end else begin
      sel_mat  = dmw1_i[`DMW_MAT];
      sel_pseg = dmw1_i[`DMW_PSEG];
    end
  end

  assign paddr_d = {sel_pseg, vaddr_i[28:0]};

  // misalignment is reported ahead of a window miss
  always_comb begin
    if (vaddr_i[1:0] != 2'b00) begin
      excp_d = EXC_ADEF_ALIGN;
    end else if (!da_mode && !dmw0_hit && !dmw1_hit) begin
      excp_d = EXC_ADEF_MAP;
    end else begin
      excp_d = EXC_NONE;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      vaddr_o    <= vaddr_i;
      paddr_o    <= paddr_d;
      uncached_o <= sel_mat != MAT_CACHED;
      excp_o     <= excp_d;
    end
  end

  a_da_no_map : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    valid_i && !stall_i && da_mode |=> excp_o != EXC_ADEF_MAP
  );

  a_uncached_mat : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    valid_i && !stall_i && !flush_i && sel_mat != MAT_CACHED |=> valid_o && uncached_o
  );

endmodule

`default_nettype wire

//--- csr_pkg.sv
`default_nettype none

package csr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // CSR write select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    CSR_CRMD = 2'd0,
    CSR_DMW0 = 2'd1,
    CSR_DMW1 = 2'd2
  } csr_addr_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // CSR contents
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one full CSR word, fields picked out with the cfg bit ranges
  typedef logic [31:0] csr_word_t;

  // memory-access type, as held in CRMD.DATF and DMW.MAT
  typedef logic [1:0] mat_t;

  // privilege level, as held in CRMD.PLV
  typedef logic [1:0] plv_t;

endpackage

`default_nettype wire

//--- fetch_csr_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_xlat_cfg.svh"

module fetch_csr_regs
  import csr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      arst_n_i,
  input  wire logic      csr_we_i,
  input  wire csr_addr_e csr_addr_i,
  input  wire csr_word_t csr_wdata_i,
  output csr_word_t      crmd_o,
  output csr_word_t      dmw0_o,
  output csr_word_t      dmw1_o,
  output logic           xlat_flush_o
);

  csr_word_t crmd_q;
  csr_word_t dmw0_q;
  csr_word_t dmw1_q;
  logic      flush_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crmd_q <= `CRMD_RESET;
      dmw0_q <= '0;
      dmw1_q <= '0;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        CSR_CRMD: crmd_q <= csr_wdata_i;
        CSR_DMW0: dmw0_q <= csr_wdata_i;
        CSR_DMW1: dmw1_q <= csr_wdata_i;
        default: ;
      endcase
    end
  end

  // any write may change the mapping, so in-flight translations are stale
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= csr_we_i;
    end
  end

  assign crmd_o       = crmd_q;
  assign dmw0_o       = dmw0_q;
  assign dmw1_o       = dmw1_q;
  assign xlat_flush_o = flush_q;

  // back-to-back flush only from writes on back-to-back edges
  a_flush_single : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    xlat_flush_o && $past(xlat_flush_o) |-> $past(csr_we_i, 1) && $past(csr_we_i, 2)
  );

endmodule

`default_nettype wire

//--- fetch_pc_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_xlat_cfg.svh"

module fetch_pc_gen (
  input  wire logic        clk,
  input  wire logic        arst_n_i,
  input  wire logic        stall_i,
  input  wire logic        redirect_i,
  input  wire logic        flush_i,
  input  wire logic [31:0] redirect_pc_i,
  output logic             pc_valid_o,
  output logic [31:0]      pc_o
);

  logic [31:0] pc_q;
  logic        started_q;

  // first cycle out of reset presents RESET_PC as not yet valid
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next pc: redirect, then flush refetch, then stall, then step
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= `RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (flush_i || stall_i || !started_q) begin
      pc_q <= pc_q;
    end else begin
      pc_q <= pc_q + `FETCH_STEP;
    end
  end

  assign pc_valid_o = started_q;
  assign pc_o       = pc_q;

  a_seq_step : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    pc_valid_o && !redirect_i && !flush_i && !stall_i |=> pc_o == $past(pc_o) + `FETCH_STEP
  );

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  import csr_pkg::*;

  // address-error cause reported with each fetch
  typedef enum logic [1:0] {
    EXC_NONE       = 2'd0,
    EXC_ADEF_ALIGN = 2'd1,
    EXC_ADEF_MAP   = 2'd2
  } fetch_excp_e;

  // coherent cached, every other type is treated as uncached
  localparam mat_t MAT_CACHED = 2'd1;

endpackage

`default_nettype wire

//--- fetch_xlat_cfg.svh
`ifndef FETCH_XLAT_CFG_SVH
`define FETCH_XLAT_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRMD fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CRMD_PLV   1:0
`define CRMD_DA    3
// memory-access type used while DA is set
`define CRMD_DATF  6:5

// DA set, PLV 0, DATF 0 (uncached)
`define CRMD_RESET 32'h0000_0008

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMW fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DMW_PLV0   0
`define DMW_PLV3   3
`define DMW_MAT    5:4
`define DMW_PSEG   27:25
`define DMW_VSEG   31:29

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RESET_PC   32'h1c00_0000
`define FETCH_STEP 32'd4

`endif

//--- fetch_xlat_top.f
+incdir+.
csr_pkg.sv
fetch_pkg.sv
fetch_csr_regs.sv
fetch_pc_gen.sv
core_iaddr_trans.sv
fetch_xlat_top.sv
tb_fetch_xlat.sv

//--- fetch_xlat_top.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_xlat_top
  import csr_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n_i,
  input  wire logic        stall_i,
  input  wire logic        redirect_i,
  input  wire logic [31:0] redirect_pc_i,
  input  wire logic        csr_we_i,
  input  wire csr_addr_e   csr_addr_i,
  input  wire csr_word_t   csr_wdata_i,
  output logic             fetch_valid_o,
  output logic [31:0]      fetch_vaddr_o,
  output logic [31:0]      fetch_paddr_o,
  output logic             fetch_uncached_o,
  output fetch_excp_e      fetch_excp_o
);

  csr_word_t   crmd;
  csr_word_t   dmw0;
  csr_word_t   dmw1;
  logic        xlat_flush;
  logic        pc_valid;
  logic [31:0] pc;

  fetch_csr_regs i_csr_regs (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .crmd_o       (crmd),
    .dmw0_o       (dmw0),
    .dmw1_o       (dmw1),
    .xlat_flush_o (xlat_flush)
  );

  fetch_pc_gen i_pc_gen (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .flush_i       (xlat_flush),
    .redirect_pc_i (redirect_pc_i),
    .pc_valid_o    (pc_valid),
    .pc_o          (pc)
  );

  // same stall as the pc stage, so both stages move together
  core_iaddr_trans i_iaddr_trans (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .valid_i    (pc_valid),
    .vaddr_i    (pc),
    .stall_i    (stall_i),
    .flush_i    (xlat_flush),
    .crmd_i     (crmd),
    .dmw0_i     (dmw0),
    .dmw1_i     (dmw1),
    .valid_o    (fetch_valid_o),
    .vaddr_o    (fetch_vaddr_o),
    .paddr_o    (fetch_paddr_o),
    .uncached_o (fetch_uncached_o),
    .excp_o     (fetch_excp_o)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch translation testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f fetch_xlat_top.f \
  --top-module tb_fetch_xlat \
  -o tb_fetch_xlat

./obj_dir/tb_fetch_xlat | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"

//--- tb_fetch_xlat.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_xlat_cfg.svh"

module tb_fetch_xlat
  import csr_pkg::*;
  import fetch_pkg::*;
();

  localparam int NUM_ROWS = 9;

  logic        clk;
  logic        arst_n_i;
  logic        stall_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic        csr_we_i;
  csr_addr_e   csr_addr_i;
  csr_word_t   csr_wdata_i;
  logic        fetch_valid_o;
  logic [31:0] fetch_vaddr_o;
  logic [31:0] fetch_paddr_o;
  logic        fetch_uncached_o;
  fetch_excp_e fetch_excp_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table, row 0 runs on the reset CSR values without writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  string       row_name [NUM_ROWS] = '{"reset_da", "plv0_dmw0", "both_hit_dmw0_wins",
                                       "plv3_map_error", "plv3_dmw1", "da_misaligned",
                                       "align_over_map", "rnd_stall_mapped", "rnd_stall_da"};
  logic [31:0] row_crmd [NUM_ROWS] = '{`CRMD_RESET, 32'h0, 32'h0, 32'h3, 32'h3, 32'h28,
                                       32'h3, 32'h0, 32'h28};
  logic [31:0] row_dmw0 [NUM_ROWS] = '{32'h0, 32'h8000_0011, 32'h8400_0011, 32'h8000_0011,
                                       32'h8000_0011, 32'h0, 32'h0, 32'h8000_0011, 32'h0};
  logic [31:0] row_dmw1 [NUM_ROWS] = '{32'h0, 32'ha000_0001, 32'h8600_0001, 32'h4200_0018,
                                       32'h4200_0018, 32'h0, 32'h0, 32'ha000_0001, 32'h0};
  logic [31:0] row_pc   [NUM_ROWS] = '{`RESET_PC, 32'h8000_1000, 32'h8000_2000, 32'h8000_0100,
                                       32'h4000_0200, 32'h1c00_0002, 32'h9000_0001,
                                       32'h8000_4000, 32'h1c00_8000};
  int          row_count [NUM_ROWS] = '{4, 8, 8, 6, 6, 5, 5, 40, 30};
  bit          row_rnd   [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 1};

  int          cur_row    = 0;
  int          items_seen = 0;
  logic [31:0] exp_vaddr  = `RESET_PC;
  logic [31:0] last_vaddr = '0;
  logic        stall_seen = 1'b0;
  int          cycles     = 0;
  int          cycle_limit;
  logic [31:0] seed_value;
  logic [31:0] rnd;

  fetch_xlat_top i_dut (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .stall_i          (stall_i),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .csr_we_i         (csr_we_i),
    .csr_addr_i       (csr_addr_i),
    .csr_wdata_i      (csr_wdata_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_vaddr_o    (fetch_vaddr_o),
    .fetch_paddr_o    (fetch_paddr_o),
    .fetch_uncached_o (fetch_uncached_o),
    .fetch_excp_o     (fetch_excp_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: test %s %s expected %h actual %h", test_name, field, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "fetch output mismatch");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic window_hit(input logic [31:0] dmw, input plv_t plv,
                                      input logic [2:0] vseg);
    logic plv_ok;
    plv_ok = (plv == 2'd0) ? dmw[`DMW_PLV0] : (plv == 2'd3) ? dmw[`DMW_PLV3] : 1'b0;
    return plv_ok && (dmw[`DMW_VSEG] == vseg);
  endfunction

  task automatic translate(input logic [31:0] va, input logic [31:0] crmd,
                           input logic [31:0] dmw0, input logic [31:0] dmw1,
                           output logic mapped, output logic [31:0] pa,
                           output logic unc, output fetch_excp_e cause);
    logic [1:0] mat;
    mapped = 1'b1;
    if (crmd[`CRMD_DA]) begin
      pa  = va;
      mat = crmd[`CRMD_DATF];
    end else if (window_hit(dmw0, crmd[`CRMD_PLV], va[31:29])) begin
      pa  = {dmw0[`DMW_PSEG], va[28:0]};
      mat = dmw0[`DMW_MAT];
    end else if (window_hit(dmw1, crmd[`CRMD_PLV], va[31:29])) begin
      pa  = {dmw1[`DMW_PSEG], va[28:0]};
      mat = dmw1[`DMW_MAT];
    end else begin
      mapped = 1'b0;
      pa     = '0;
      mat    = 2'd0;
    end
    unc = (mat != MAT_CACHED);
    if (va[1:0] != 2'b00) cause = EXC_ADEF_ALIGN;
    else if (!mapped) cause = EXC_ADEF_MAP;
    else cause = EXC_NONE;
  endtask

  task automatic check_item();
    logic        mapped;
    logic [31:0] pa;
    logic        unc;
    fetch_excp_e cause;
    compare_value(row_name[cur_row], "vaddr", exp_vaddr, fetch_vaddr_o);
    translate(exp_vaddr, row_crmd[cur_row], row_dmw0[cur_row], row_dmw1[cur_row],
              mapped, pa, unc, cause);
    compare_value(row_name[cur_row], "excp", 32'(cause), 32'(fetch_excp_o));
    // paddr and attribute only mean something when some mapping applies
    if (mapped) begin
      compare_value(row_name[cur_row], "paddr", pa, fetch_paddr_o);
      compare_value(row_name[cur_row], "uncached", 32'(unc), 32'(fetch_uncached_o));
    end
    last_vaddr = exp_vaddr;
    exp_vaddr  = exp_vaddr + `FETCH_STEP;
    items_seen = items_seen + 1;
  endtask

  // a valid output is a new item only if the last edge was not stalled
  always @(negedge clk) begin
    if (fetch_valid_o && !stall_seen) begin
      check_item();
    end else if (fetch_valid_o) begin
      // a stalled edge leaves the last item in place
      compare_value(row_name[cur_row], "held vaddr", last_vaddr, fetch_vaddr_o);
    end
    stall_seen = stall_i;
  end

  task automatic program_row(input int r);
    @(posedge clk);
    stall_i <= 1'b1;
    @(posedge clk);
    cur_row     = r;
    exp_vaddr   = row_pc[r];
    items_seen  = 0;
    csr_we_i    <= 1'b1;
    csr_addr_i  <= CSR_CRMD;
    csr_wdata_i <= row_crmd[r];
    @(posedge clk);
    csr_addr_i  <= CSR_DMW0;
    csr_wdata_i <= row_dmw0[r];
    @(posedge clk);
    csr_addr_i  <= CSR_DMW1;
    csr_wdata_i <= row_dmw1[r];
    @(posedge clk);
    csr_we_i      <= 1'b0;
    redirect_i    <= 1'b1;
    redirect_pc_i <= row_pc[r];
    @(posedge clk);
    redirect_i <= 1'b0;
    // stall still holds the pipe, so only the flush can have dropped the old item
    @(negedge clk);
    compare_value(row_name[r], "valid after flush", 32'd0, 32'(fetch_valid_o));
    @(posedge clk);
    stall_i <= 1'b0;
  endtask

  task automatic wait_items(input int r);
    while (items_seen < row_count[r]) begin
      @(posedge clk);
      if (row_rnd[r]) begin
        rnd = $urandom;
        stall_i <= rnd[0];
      end
    end
  endtask

  initial begin
    cycle_limit = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      cycle_limit = cycle_limit + row_count[i] * 4 + 50;
    end
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
        $display("timeout after %0d cycles, fetch outputs stopped arriving", cycles);
        $display("TEST FAILED");
        $fatal(1, "simulation timeout");
      end
    end
  end

  initial begin
    seed_value    = $urandom(52652);
    arst_n_i      = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    csr_we_i      = 1'b0;
    csr_addr_i    = CSR_CRMD;
    csr_wdata_i   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_value("reset", "valid", 32'd0, 32'(fetch_valid_o));
    @(posedge clk);
    arst_n_i <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r != 0) begin
        program_row(r);
      end
      wait_items(r);
    end
    @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
